//--- verilog/mfp_regs_pkg.sv
package mfp_regs_pkg;

  // cpu-side register bus
  typedef logic [1:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  // bit 1 picks the channel, bit 0 picks control over data
  localparam reg_addr_t ADDR_A_DATA = 2'd0;
  localparam reg_addr_t ADDR_A_CTRL = 2'd1;
  localparam reg_addr_t ADDR_B_DATA = 2'd2;
  localparam reg_addr_t ADDR_B_CTRL = 2'd3;

  // low five bits of a control register access
  // on read, clear_out position carries the output level
  typedef struct packed {
    logic       clear_out;
    logic       mode_sel;
    logic [2:0] prescale_sel;
  } ctrl_reg_t;

  localparam int CTRL_REG_W = $bits(ctrl_reg_t);

endpackage

//--- verilog/mfp_timer_pkg.sv
package mfp_timer_pkg;

  typedef logic [7:0] count_t;
  typedef logic [2:0] presc_sel_t;

  typedef enum logic [1:0] {
    MODE_STOPPED,
    MODE_DELAY,
    MODE_EVENT,
    MODE_PULSE
  } timer_mode_e;

  // per-channel config handed from control to the datapath
  typedef struct packed {
    timer_mode_e mode;
    presc_sel_t  sel;
  } timer_cfg_t;

  // divide ratio for a prescaler select
  function automatic logic [7:0] presc_ratio(presc_sel_t sel);
    case (sel)
      3'd1:    return 8'd4;
      3'd2:    return 8'd10;
      3'd3:    return 8'd16;
      3'd4:    return 8'd50;
      3'd5:    return 8'd64;
      3'd6:    return 8'd100;
      3'd7:    return 8'd200;
      default: return 8'd1;
    endcase
  endfunction

  // mode from the raw control bits
  function automatic timer_mode_e decode_mode(logic mode_sel, presc_sel_t sel);
    if (!mode_sel)
      return (sel == '0) ? MODE_STOPPED : MODE_DELAY;
    return (sel == '0) ? MODE_EVENT : MODE_PULSE;
  endfunction

endpackage

//--- verilog/mfp_input_sync.sv
module mfp_input_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic CLK,
  input  logic rst_n,
  input  logic async_in,
  output logic level,
  output logic rise
);

  logic [SYNC_STAGES-1:0] chain;
  logic                   hist;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      chain <= '0;
      hist  <= 1'b0;
    end else begin
      // shift in at bit 0, synchronised level leaves at the top
      chain <= {chain[SYNC_STAGES-2:0], async_in};
      hist  <= chain[SYNC_STAGES-1];
    end
  end

  assign level = chain[SYNC_STAGES-1];

  // high in the first cycle of a new high level
  assign rise = chain[SYNC_STAGES-1] & ~hist;

endmodule

//--- verilog/mfp_prescaler.sv
module mfp_prescaler
  import mfp_timer_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  presc_sel_t sel,
  input  logic       restart,
  input  logic       xclk_rise,
  output logic       tick
);

  logic [7:0] edge_cnt;
  logic [7:0] last_cnt;
  logic       at_last;

  // ratio of 1 gives a tick on every edge
  assign last_cnt = presc_ratio(sel) - 8'd1;

  // >= so a stale count above a new limit still wraps
  assign at_last = (edge_cnt >= last_cnt);

  assign tick = xclk_rise & at_last;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      edge_cnt <= '0;
    end else if (restart) begin
      // new select written, start the divide over
      edge_cnt <= '0;
    end else if (xclk_rise) begin
      if (at_last)
        edge_cnt <= '0;
      else
        edge_cnt <= edge_cnt + 8'd1;
    end
  end

endmodule

//--- verilog/mfp_timer_counter.sv
module mfp_timer_counter
  import mfp_timer_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   load,
  input  count_t load_value,
  input  logic   count_en,
  input  logic   clear_out,
  output count_t count,
  output logic   t_out,
  output logic   timeout
);

  count_t reload_q;
  count_t count_q;
  logic   out_q;
  logic   timeout_q;
  logic   wrap;

  // only 1 ends a period, a zero count runs down through 255
  assign wrap = count_en && !load && (count_q == 8'd1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      reload_q <= '0;
      count_q  <= '0;
    end else if (load) begin
      // data write sets both reload and live count
      reload_q <= load_value;
      count_q  <= load_value;
    end else if (count_en) begin
      if (wrap)
        count_q <= reload_q;
      else
        count_q <= count_q - 8'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      out_q     <= 1'b0;
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= wrap;
      // clear wins over a toggle in the same cycle
      if (clear_out)
        out_q <= 1'b0;
      else if (wrap)
        out_q <= ~out_q;
    end
  end

  assign count   = count_q;
  assign t_out   = out_q;
  assign timeout = timeout_q;

endmodule

//--- verilog/mfp_timer_ctrl.sv
module mfp_timer_ctrl
  import mfp_regs_pkg::*, mfp_timer_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  reg_addr_t  addr,
  input  logic       wr,
  input  reg_data_t  wdata,
  output reg_data_t  rdata,
  output timer_cfg_t cfg_a,
  output timer_cfg_t cfg_b,
  output logic       presc_restart_a,
  output logic       presc_restart_b,
  input  logic       tick_a,
  input  logic       tick_b,
  input  logic       trig_level_a,
  input  logic       trig_level_b,
  input  logic       trig_rise_a,
  input  logic       trig_rise_b,
  output logic       load_a,
  output logic       load_b,
  output count_t     load_value,
  output logic       clear_a,
  output logic       clear_b,
  output logic       count_en_a,
  output logic       count_en_b,
  input  count_t     count_a,
  input  count_t     count_b,
  input  logic       t_out_a,
  input  logic       t_out_b,
  output logic       pulse_mode_a,
  output logic       pulse_mode_b
);

  ctrl_reg_t  wr_ctrl;
  logic       wr_ctrl_a;
  logic       wr_ctrl_b;
  timer_cfg_t new_cfg;
  ctrl_reg_t  rd_ctrl_a;
  ctrl_reg_t  rd_ctrl_b;

  // count source picked by the channel mode
  function automatic logic count_src(timer_cfg_t cfg, logic tick, logic trig_level,
                                     logic trig_rise);
    case (cfg.mode)
      MODE_DELAY: return tick;
      MODE_EVENT: return trig_rise;
      MODE_PULSE: return tick & trig_level;
      default:    return 1'b0;
    endcase
  endfunction

  // write decode
  assign wr_ctrl   = ctrl_reg_t'(wdata[CTRL_REG_W-1:0]);
  assign wr_ctrl_a = wr && (addr == ADDR_A_CTRL);
  assign wr_ctrl_b = wr && (addr == ADDR_B_CTRL);
  assign load_a    = wr && (addr == ADDR_A_DATA);
  assign load_b    = wr && (addr == ADDR_B_DATA);
  assign load_value = wdata;
  assign clear_a   = wr_ctrl_a & wr_ctrl.clear_out;
  assign clear_b   = wr_ctrl_b & wr_ctrl.clear_out;
  assign presc_restart_a = wr_ctrl_a;
  assign presc_restart_b = wr_ctrl_b;

  assign new_cfg.mode = decode_mode(wr_ctrl.mode_sel, wr_ctrl.prescale_sel);
  assign new_cfg.sel  = wr_ctrl.prescale_sel;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cfg_a <= '{mode: MODE_STOPPED, sel: '0};
      cfg_b <= '{mode: MODE_STOPPED, sel: '0};
    end else begin
      if (wr_ctrl_a)
        cfg_a <= new_cfg;
      if (wr_ctrl_b)
        cfg_b <= new_cfg;
    end
  end

  assign count_en_a   = count_src(cfg_a, tick_a, trig_level_a, trig_rise_a);
  assign count_en_b   = count_src(cfg_b, tick_b, trig_level_b, trig_rise_b);
  assign pulse_mode_a = (cfg_a.mode == MODE_PULSE);
  assign pulse_mode_b = (cfg_b.mode == MODE_PULSE);

  // control readback, output level sits where clear_out is written
  assign rd_ctrl_a.clear_out    = t_out_a;
  assign rd_ctrl_a.mode_sel     = (cfg_a.mode == MODE_EVENT) || (cfg_a.mode == MODE_PULSE);
  assign rd_ctrl_a.prescale_sel = cfg_a.sel;
  assign rd_ctrl_b.clear_out    = t_out_b;
  assign rd_ctrl_b.mode_sel     = (cfg_b.mode == MODE_EVENT) || (cfg_b.mode == MODE_PULSE);
  assign rd_ctrl_b.prescale_sel = cfg_b.sel;

  always_comb begin
    case (addr)
      ADDR_A_DATA: rdata = count_a;
      ADDR_A_CTRL: rdata = reg_data_t'(rd_ctrl_a);
      ADDR_B_DATA: rdata = count_b;
      default:     rdata = reg_data_t'(rd_ctrl_b);
    endcase
  end

endmodule

//--- verilog/mfp_timer_block.sv
module mfp_timer_block
  import mfp_regs_pkg::*, mfp_timer_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic      CLK,
  input  logic      rst_n,
  input  reg_addr_t addr,
  input  logic      wr,
  input  reg_data_t wdata,
  output reg_data_t rdata,
  input  logic      xclk_a,
  input  logic      xclk_b,
  input  logic      trig_a,
  input  logic      trig_b,
  output logic      t_out_a,
  output logic      t_out_b,
  output logic      timeout_a,
  output logic      timeout_b,
  output logic      pulse_mode_a,
  output logic      pulse_mode_b
);

  timer_cfg_t cfg_a, cfg_b;
  logic       restart_a, restart_b;
  logic       xrise_a, xrise_b;
  logic       tick_a, tick_b;
  logic       trig_lvl_a, trig_lvl_b;
  logic       trig_rise_a, trig_rise_b;
  logic       load_a, load_b;
  count_t     load_value;
  logic       clear_a, clear_b;
  logic       count_en_a, count_en_b;
  count_t     count_a, count_b;

  mfp_timer_ctrl u_ctrl (
    .CLK, .rst_n, .addr, .wr, .wdata, .rdata,
    .cfg_a, .cfg_b,
    .presc_restart_a (restart_a), .presc_restart_b (restart_b),
    .tick_a, .tick_b,
    .trig_level_a (trig_lvl_a), .trig_level_b (trig_lvl_b),
    .trig_rise_a, .trig_rise_b,
    .load_a, .load_b, .load_value, .clear_a, .clear_b,
    .count_en_a, .count_en_b, .count_a, .count_b,
    .t_out_a, .t_out_b, .pulse_mode_a, .pulse_mode_b
  );

  // channel a
  mfp_input_sync #(.SYNC_STAGES(SYNC_STAGES)) u_xsync_a (
    .CLK, .rst_n, .async_in (xclk_a), .level (), .rise (xrise_a));
  mfp_input_sync #(.SYNC_STAGES(SYNC_STAGES)) u_tsync_a (
    .CLK, .rst_n, .async_in (trig_a), .level (trig_lvl_a), .rise (trig_rise_a));
  mfp_prescaler u_presc_a (
    .CLK, .rst_n, .sel (cfg_a.sel), .restart (restart_a), .xclk_rise (xrise_a), .tick (tick_a));
  mfp_timer_counter u_cnt_a (
    .CLK, .rst_n, .load (load_a), .load_value, .count_en (count_en_a), .clear_out (clear_a),
    .count (count_a), .t_out (t_out_a), .timeout (timeout_a));

  // channel b
  mfp_input_sync #(.SYNC_STAGES(SYNC_STAGES)) u_xsync_b (
    .CLK, .rst_n, .async_in (xclk_b), .level (), .rise (xrise_b));
  mfp_input_sync #(.SYNC_STAGES(SYNC_STAGES)) u_tsync_b (
    .CLK, .rst_n, .async_in (trig_b), .level (trig_lvl_b), .rise (trig_rise_b));
  mfp_prescaler u_presc_b (
    .CLK, .rst_n, .sel (cfg_b.sel), .restart (restart_b), .xclk_rise (xrise_b), .tick (tick_b));
  mfp_timer_counter u_cnt_b (
    .CLK, .rst_n, .load (load_b), .load_value, .count_en (count_en_b), .clear_out (clear_b),
    .count (count_b), .t_out (t_out_b), .timeout (timeout_b));

endmodule

//--- test/mfp_timer_block_asserts.sv
module mfp_timer_block_asserts
  import mfp_regs_pkg::*, mfp_timer_pkg::*;
(
  input logic       CLK,
  input logic       rst_n,
  input reg_addr_t  addr,
  input logic       wr,
  input reg_data_t  wdata,
  input logic       timeout_a,
  input logic       timeout_b,
  input logic       t_out_a,
  input logic       t_out_b,
  input logic       pulse_mode_a,
  input logic       pulse_mode_b,
  input timer_cfg_t cfg_a,
  input timer_cfg_t cfg_b,
  input count_t     count_a,
  input count_t     count_b,
  input logic       load_a,
  input logic       load_b,
  input logic       clear_a,
  input logic       clear_b
);
  timeunit 1ns;
  timeprecision 100ps;

  int   fail_cnt = 0;
  logic wr_ctrl_a;
  logic wr_ctrl_b;
  logic wr_pulse;

  assign wr_ctrl_a = wr && (addr == ADDR_A_CTRL);
  assign wr_ctrl_b = wr && (addr == ADDR_B_CTRL);
  // mode_sel with a nonzero select asks for pulse mode
  assign wr_pulse  = wdata[3] && (wdata[2:0] != 3'd0);

  // timeout is a single-cycle pulse
  a_to_single_a: assert property (@(posedge CLK) disable iff (!rst_n)
      timeout_a |=> !timeout_a)
    else begin
      fail_cnt++;
      $error("timeout_a high two cycles in a row");
    end
  a_to_single_b: assert property (@(posedge CLK) disable iff (!rst_n)
      timeout_b |=> !timeout_b)
    else begin
      fail_cnt++;
      $error("timeout_b high two cycles in a row");
    end

  // output level moves only on a wrap or a clear
  a_out_a: assert property (@(posedge CLK) disable iff (!rst_n)
      $changed(t_out_a) |-> timeout_a || $past(clear_a))
    else begin
      fail_cnt++;
      $error("t_out_a changed without timeout or clear");
    end
  a_out_b: assert property (@(posedge CLK) disable iff (!rst_n)
      $changed(t_out_b) |-> timeout_b || $past(clear_b))
    else begin
      fail_cnt++;
      $error("t_out_b changed without timeout or clear");
    end

  // stopped channel holds its count
  a_stop_a: assert property (@(posedge CLK) disable iff (!rst_n)
      cfg_a.mode == MODE_STOPPED && !load_a |=> $stable(count_a))
    else begin
      fail_cnt++;
      $error("count_a moved while stopped");
    end
  a_stop_b: assert property (@(posedge CLK) disable iff (!rst_n)
      cfg_b.mode == MODE_STOPPED && !load_b |=> $stable(count_b))
    else begin
      fail_cnt++;
      $error("count_b moved while stopped");
    end

  // pulse_mode follows the last control write to its channel
  a_pm_a: assert property (@(posedge CLK) disable iff (!rst_n)
      pulse_mode_a == ($past(wr_ctrl_a) ? $past(wr_pulse) : $past(pulse_mode_a)))
    else begin
      fail_cnt++;
      $error("pulse_mode_a disagrees with the written control register");
    end
  a_pm_b: assert property (@(posedge CLK) disable iff (!rst_n)
      pulse_mode_b == ($past(wr_ctrl_b) ? $past(wr_pulse) : $past(pulse_mode_b)))
    else begin
      fail_cnt++;
      $error("pulse_mode_b disagrees with the written control register");
    end

endmodule

bind mfp_timer_block mfp_timer_block_asserts u_asserts (.*);

//--- test/mfp_timer_block_tb.sv
module mfp_timer_block_tb
  import mfp_regs_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SYNC_STAGES = 2;
  localparam int HOLD = SYNC_STAGES + 2;
  // worst-case length of all tests in clock cycles
  localparam int TEST_CYCLES = 700;

  logic CLK = 1'b0;
  logic rst_n, wr, xclk_a, xclk_b, trig_a, trig_b;
  reg_addr_t addr;
  reg_data_t wdata, rdata, rd;
  logic t_out_a, t_out_b, timeout_a, timeout_b, pulse_mode_a, pulse_mode_b;
  int errors = 0;
  int to_a = 0;
  int to_b = 0;
  logic [31:0] seed = 32'hf0a7;
  int n, model;

  mfp_timer_block #(.SYNC_STAGES(SYNC_STAGES)) UUT (.*);

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    if (rst_n && timeout_a) to_a <= to_a + 1;
    if (rst_n && timeout_b) to_b <= to_b + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_eq(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic write_reg(input reg_addr_t a, input reg_data_t d);
    @(negedge CLK);
    addr = a;
    wdata = d;
    wr = 1'b1;
    @(negedge CLK);
    wr = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t a, output reg_data_t d);
    @(negedge CLK);
    addr = a;
    #5 d = rdata;
  endtask

  // one rising edge on both xclk inputs, each level held past the synchroniser
  task automatic xclk_edges(input int cnt);
    repeat (cnt) begin
      @(negedge CLK);
      xclk_a = 1'b1;
      xclk_b = 1'b1;
      repeat (HOLD) @(negedge CLK);
      xclk_a = 1'b0;
      xclk_b = 1'b0;
      repeat (HOLD) @(negedge CLK);
    end
  endtask

  task automatic trig_edge();
    seed = lcg_next(seed);
    @(negedge CLK);
    trig_a = 1'b1;
    trig_b = 1'b1;
    repeat (HOLD) @(negedge CLK);
    trig_a = 1'b0;
    trig_b = 1'b0;
    repeat (HOLD + int'(seed[17:16])) @(negedge CLK);
  endtask

  task automatic wait_timeouts(input int exp, input int max_cycles);
    int i;
    for (i = 0; i < max_cycles && to_a != exp; i++) @(negedge CLK);
    if (to_a != exp) begin
      $display("no timeout on channel A within %0d cycles", max_cycles);
      errors++;
    end
  endtask

  initial begin
    #(2 * TEST_CYCLES * 20);
    $display("watchdog expired, tests did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    {rst_n, wr, xclk_a, xclk_b, trig_a, trig_b} = '0;
    addr = '0;
    wdata = '0;
    repeat (3) @(negedge CLK);
    rst_n = 1'b1;
    // reset state
    check_eq("reset_outs", 0, {t_out_a, t_out_b, timeout_a, timeout_b, pulse_mode_a, pulse_mode_b});
    for (int a = 0; a < 4; a++) begin
      read_reg(reg_addr_t'(a), rd);
      check_eq("reset_read", 0, rd);
    end
    // register access
    write_reg(ADDR_A_DATA, 8'h5a);
    read_reg(ADDR_A_DATA, rd);
    check_eq("data_a_rw", 8'h5a, rd);
    write_reg(ADDR_B_DATA, 8'h33);
    read_reg(ADDR_B_DATA, rd);
    check_eq("data_b_rw", 8'h33, rd);
    write_reg(ADDR_A_CTRL, 8'h05);
    read_reg(ADDR_A_CTRL, rd);
    check_eq("ctrl_a_rw", 8'h05, rd);
    // event mode, random reload
    seed = lcg_next(seed);
    n = 2 + int'(seed[18:16] % 3'd6);
    write_reg(ADDR_A_DATA, reg_data_t'(n));
    write_reg(ADDR_A_CTRL, 8'h08);
    for (int k = 1; k < n; k++) begin
      trig_edge();
      read_reg(ADDR_A_DATA, rd);
      check_eq("event_count", n - k, rd);
    end
    trig_edge();
    wait_timeouts(1, 4 * HOLD);
    repeat (HOLD) @(negedge CLK);
    check_eq("event_timeouts", 1, to_a);
    check_eq("event_t_out", 1, t_out_a);
    read_reg(ADDR_A_DATA, rd);
    check_eq("event_reload", n, rd);
    read_reg(ADDR_A_CTRL, rd);
    check_eq("ctrl_out_bit", 8'h18, rd);
    // clear_out
    write_reg(ADDR_A_CTRL, 8'h18);
    read_reg(ADDR_A_CTRL, rd);
    check_eq("clear_read", 8'h08, rd);
    check_eq("clear_t_out", 0, t_out_a);
    // delay mode, ratio 4, reload 3
    write_reg(ADDR_A_DATA, 8'd3);
    write_reg(ADDR_A_CTRL, 8'h01);
    xclk_edges(11);
    read_reg(ADDR_A_DATA, rd);
    check_eq("delay_count", 3 - 11 / 4, rd);
    check_eq("delay_early", 1, to_a);
    xclk_edges(1);
    wait_timeouts(2, 4 * HOLD);
    check_eq("delay_t_out1", 1, t_out_a);
    xclk_edges(12);
    wait_timeouts(3, 4 * HOLD);
    check_eq("delay_t_out2", 0, t_out_a);
    // pulse mode, ratio 4, reload 5
    write_reg(ADDR_A_DATA, 8'd5);
    write_reg(ADDR_A_CTRL, 8'h09);
    xclk_edges(8);
    read_reg(ADDR_A_DATA, rd);
    check_eq("pulse_trig_low", 5, rd);
    check_eq("pulse_mode_on", 1, pulse_mode_a);
    @(negedge CLK) trig_a = 1'b1;
    repeat (HOLD) @(negedge CLK);
    xclk_edges(8);
    model = 5 - 8 / 4;
    read_reg(ADDR_A_DATA, rd);
    check_eq("pulse_trig_high", model, rd);
    @(negedge CLK) trig_a = 1'b0;
    repeat (HOLD) @(negedge CLK);
    xclk_edges(4);
    read_reg(ADDR_A_DATA, rd);
    check_eq("pulse_frozen", model, rd);
    check_eq("pulse_mode_hold", 1, pulse_mode_a);
    // channel B untouched
    read_reg(ADDR_B_DATA, rd);
    check_eq("chan_b_count", 8'h33, rd);
    check_eq("chan_b_timeouts", 0, to_b);
    check_eq("chan_b_t_out", 0, t_out_b);
    check_eq("chan_b_pulse_mode", 0, pulse_mode_b);
    $display("errors: %0d readback, %0d assertion", errors, UUT.u_asserts.fail_cnt);
    if (errors == 0 && UUT.u_asserts.fail_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- mfp_timer_block.f
verilog/mfp_regs_pkg.sv
verilog/mfp_timer_pkg.sv
verilog/mfp_input_sync.sv
verilog/mfp_prescaler.sv
verilog/mfp_timer_counter.sv
verilog/mfp_timer_ctrl.sv
verilog/mfp_timer_block.sv
test/mfp_timer_block_asserts.sv
test/mfp_timer_block_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       ?= mfp_timer_block_tb
FILELIST  ?= mfp_timer_block.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
